//--- verilog/zx_mapper_defs.svh
`ifndef ZX_MAPPER_DEFS_SVH
`define ZX_MAPPER_DEFS_SVH

////////////////////////////////////////////////////////////
// cpu window layout
////////////////////////////////////////////////////////////

// four 16k windows over the z80 address space
`define ZX_WINDOWS     4
`define ZX_WIN_BITS    14
`define ZX_PAGE_BITS   6

////////////////////////////////////////////////////////////
// port and dos decoding
////////////////////////////////////////////////////////////

// low address byte of the pager port
`define ZX_PAGER_PORT  (8'hF7)
// opcode fetch from this high byte enters dos
`define ZX_DOS_ENTRY   (8'h3D)

// mapping after reset, window 0 is rom
`define ZX_RST_PAGE0   (6'd0)
`define ZX_RST_PAGE1   (6'd5)
`define ZX_RST_PAGE2   (6'd2)
`define ZX_RST_PAGE3   (6'd0)

`endif

//--- verilog/zbus_pkg.sv
`default_nettype none

package zbus_pkg;

	////////////////////////////////////////////////////////////
	// z80 side of the bus
	////////////////////////////////////////////////////////////

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	// one bus cycle, strobes reduced to single-cycle pulses
	typedef struct packed {
		// full 16-bit address
		cpu_addr_t za;
		// write data, only meaningful with io_wr
		cpu_data_t zd;
		// i/o write pulse
		logic      io_wr;
		// memory request pulse
		logic      mem_rd;
		// opcode fetch qualifier for mem_rd
		logic      m1;
	} cpu_req_t;

endpackage

`default_nettype wire

//--- verilog/zmem_pkg.sv
`default_nettype none

`include "zx_mapper_defs.svh"

package zmem_pkg;

	////////////////////////////////////////////////////////////
	// paging
	////////////////////////////////////////////////////////////

	typedef logic [$clog2(`ZX_WINDOWS)-1:0] window_t;
	typedef logic [`ZX_PAGE_BITS-1:0]       page_t;

	// ram=0 selects rom
	typedef struct packed {
		logic  ram;
		page_t page;
	} win_cfg_t;

	// single window update from the pager port
	typedef struct packed {
		logic     valid;
		window_t  window;
		win_cfg_t cfg;
	} page_wr_t;

	////////////////////////////////////////////////////////////
	// memory side
	////////////////////////////////////////////////////////////

	typedef logic [`ZX_PAGE_BITS+`ZX_WIN_BITS-1:0] mem_addr_t;

	typedef struct packed {
		logic      valid;
		logic      rom;
		mem_addr_t addr;
	} mem_req_t;

	typedef enum logic {
		dos_off,
		dos_on
	} dos_state_t;

endpackage

`default_nettype wire

//--- verilog/port_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "zx_mapper_defs.svh"

module port_decode (
	input  wire                     fclk,
	input  wire                     rst_n,
	input  wire zbus_pkg::cpu_req_t cpu,
	output zmem_pkg::page_wr_t      pg_wr
);
	import zmem_pkg::*;

	logic     port_hit;

	// first stage, decoded pager write
	logic     smp_hit;
	window_t  smp_window;
	win_cfg_t smp_cfg;

	// second stage, update presented to the page file
	logic     upd_valid;
	window_t  upd_window;
	win_cfg_t upd_cfg;

	// memory requests never match here
	assign port_hit = cpu.io_wr && (cpu.za[7:0] == `ZX_PAGER_PORT);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			smp_hit   <= 1'b0;
			upd_valid <= 1'b0;
		end
		else
		begin
			smp_hit   <= port_hit;
			upd_valid <= smp_hit;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (port_hit)
		begin
			smp_window   <= window_t'(cpu.za[15:`ZX_WIN_BITS]);
			// bit 7 is ram/rom, bit 6 unused
			smp_cfg.ram  <= cpu.zd[7];
			smp_cfg.page <= page_t'(cpu.zd[`ZX_PAGE_BITS-1:0]);
		end
		if (smp_hit)
		begin
			upd_window <= smp_window;
			upd_cfg    <= smp_cfg;
		end
	end

	assign pg_wr = '{valid: upd_valid, window: upd_window, cfg: upd_cfg};

endmodule

`default_nettype wire

//--- verilog/page_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "zx_mapper_defs.svh"

module page_file (
	input  wire                     fclk,
	input  wire                     rst_n,
	input  wire zmem_pkg::page_wr_t pg_wr,
	output zmem_pkg::win_cfg_t      win_cfg [0:`ZX_WINDOWS-1]
);
	import zmem_pkg::*;

	win_cfg_t cfg_q [0:`ZX_WINDOWS-1];

	////////////////////////////////////////////////////////////
	// reset mapping
	////////////////////////////////////////////////////////////

	// rom 0 low, then ram 5, 2, 0
	function automatic win_cfg_t rst_cfg(input window_t win);
		win_cfg_t cfg;
		case (win)
			window_t'(0):
			begin
				cfg.ram  = 1'b0;
				cfg.page = `ZX_RST_PAGE0;
			end
			window_t'(1):
			begin
				cfg.ram  = 1'b1;
				cfg.page = `ZX_RST_PAGE1;
			end
			window_t'(2):
			begin
				cfg.ram  = 1'b1;
				cfg.page = `ZX_RST_PAGE2;
			end
			default:
			begin
				cfg.ram  = 1'b1;
				cfg.page = `ZX_RST_PAGE3;
			end
		endcase
		return cfg;
	endfunction

	////////////////////////////////////////////////////////////
	// window registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `ZX_WINDOWS; i++)
				cfg_q[i] <= rst_cfg(window_t'(i));
		end
		else if (pg_wr.valid)
		begin
			// only the addressed window changes
			cfg_q[pg_wr.window] <= pg_wr.cfg;
		end
	end

	// current contents, no extra delay
	assign win_cfg = cfg_q;

endmodule

`default_nettype wire

//--- verilog/mem_translator.sv
`timescale 1ns/1ps
`default_nettype none

`include "zx_mapper_defs.svh"

module mem_translator (
	input  wire                     fclk,
	input  wire                     rst_n,
	input  wire zbus_pkg::cpu_req_t cpu,
	input  wire zmem_pkg::win_cfg_t win_cfg [0:`ZX_WINDOWS-1],
	output zmem_pkg::mem_req_t      mem,
	output logic                    dos
);
	import zmem_pkg::*;

	window_t                 req_window;
	win_cfg_t                req_cfg;
	logic                    m1_fetch;

	// stage 1
	logic                    s1_valid;
	logic [`ZX_WIN_BITS-1:0] s1_off;
	win_cfg_t                s1_cfg;
	mem_addr_t               s1_addr;

	// stage 2
	logic                    s2_valid;
	logic                    s2_rom;
	mem_addr_t               s2_addr;

	dos_state_t              dos_state;
	dos_state_t              dos_next;

	assign req_window = window_t'(cpu.za[15:`ZX_WIN_BITS]);
	assign req_cfg    = win_cfg[req_window];
	assign m1_fetch   = cpu.mem_rd && cpu.m1;

	////////////////////////////////////////////////////////////
	// request pipeline
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= cpu.mem_rd;
			s2_valid <= s1_valid;
		end
	end

	// window config is frozen with the request
	always_ff @(posedge fclk)
	begin
		if (cpu.mem_rd)
		begin
			s1_off <= cpu.za[`ZX_WIN_BITS-1:0];
			s1_cfg <= req_cfg;
		end
		if (s1_valid)
		begin
			s2_rom  <= !s1_cfg.ram;
			s2_addr <= s1_addr;
		end
	end

	// rom space is half the size, top bit forced low
	always_comb
	begin
		if (s1_cfg.ram)
			s1_addr = {s1_cfg.page, s1_off};
		else
			s1_addr = {1'b0, s1_cfg.page[`ZX_PAGE_BITS-2:0], s1_off};
	end

	assign mem = '{valid: s2_valid, rom: s2_rom, addr: s2_addr};

	////////////////////////////////////////////////////////////
	// dos fsm
	////////////////////////////////////////////////////////////

	always_comb
	begin
		dos_next = dos_state;
		if (m1_fetch)
		begin
			case (dos_state)
				dos_off:
					if (cpu.za[15:8] == `ZX_DOS_ENTRY && !win_cfg[0].ram)
						dos_next = dos_on;
				dos_on:
					// any fetch outside window 0
					if (req_window != '0)
						dos_next = dos_off;
				default:
					dos_next = dos_off;
			endcase
		end
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			dos_state <= dos_off;
		else
			dos_state <= dos_next;
	end

	assign dos = (dos_state == dos_on);

endmodule

`default_nettype wire

//--- verilog/zx_mapper.sv
`timescale 1ns/1ps
`default_nettype none

`include "zx_mapper_defs.svh"

module zx_mapper (
	input  wire                     fclk,
	input  wire                     rst_n,
	input  wire zbus_pkg::cpu_req_t cpu,
	output zmem_pkg::mem_req_t      mem,
	output logic                    dos
);
	import zmem_pkg::*;

	page_wr_t pg_wr;
	win_cfg_t win_cfg [0:`ZX_WINDOWS-1];

	////////////////////////////////////////////////////////////
	// pager port
	////////////////////////////////////////////////////////////

	port_decode port_decode (
		.fclk  (fclk),
		.rst_n (rst_n),
		.cpu   (cpu),
		.pg_wr (pg_wr)
	);

	// one register per cpu window
	page_file page_file (
		.fclk    (fclk),
		.rst_n   (rst_n),
		.pg_wr   (pg_wr),
		.win_cfg (win_cfg)
	);

	////////////////////////////////////////////////////////////
	// cpu to rom/ram address
	////////////////////////////////////////////////////////////

	mem_translator mem_translator (
		.fclk    (fclk),
		.rst_n   (rst_n),
		.cpu     (cpu),
		.win_cfg (win_cfg),
		.mem     (mem),
		.dos     (dos)
	);

endmodule

`default_nettype wire

//--- bench/zx_mapper_props.sv
`timescale 1ns/1ps
`default_nettype none

module zx_mapper_props (
	input wire                     fclk,
	input wire                     rst_n,
	input wire zbus_pkg::cpu_req_t cpu,
	input wire zmem_pkg::mem_req_t mem,
	input wire                     dos
);

	////////////////////////////////////////////////////////////
	// read pipeline latency
	////////////////////////////////////////////////////////////

	read_latency_a: assert property (
		@(posedge fclk) disable iff (!rst_n)
		cpu.mem_rd |-> ##2 mem.valid
	)
	else
		$error("memory read not answered two cycles later");

	// no result without a request
	no_spurious_a: assert property (
		@(posedge fclk) disable iff (!rst_n)
		mem.valid |-> $past(cpu.mem_rd, 2)
	)
	else
		$error("mem.valid without a read two cycles earlier");

	////////////////////////////////////////////////////////////
	// dos flag
	////////////////////////////////////////////////////////////

	dos_change_a: assert property (
		@(posedge fclk) disable iff (!rst_n)
		(dos != $past(dos)) |-> $past(cpu.mem_rd && cpu.m1)
	)
	else
		$error("dos changed without an opcode fetch one cycle before");

endmodule

`default_nettype wire

//--- bench/zx_mapper_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "zx_mapper_defs.svh"

module zx_mapper_tb;
	import zbus_pkg::*;
	import zmem_pkg::*;

	localparam int RAND_ROUNDS     = 40;
	localparam int READS_PER_ROUND = 6;
	localparam int OTHER_ROUNDS    = 12;
	localparam int ORDER_ROUNDS    = 16;
	localparam int DOS_CYCLES      = 26;
	// reset, reset reads and drain plus the worst case of every test
	localparam int STIM_CYCLES = 6 + 8 + 10 + DOS_CYCLES
		+ RAND_ROUNDS * (3 + 2 * READS_PER_ROUND)
		+ OTHER_ROUNDS * 7 + ORDER_ROUNDS * 7;
	localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

	typedef struct packed {
		int       eff;
		window_t  win;
		win_cfg_t cfg;
	} pend_t;

	typedef struct packed {
		int       due;
		mem_req_t req;
	} mem_exp_t;

	typedef struct packed {
		int   due;
		logic val;
	} dos_exp_t;

	logic     fclk;
	logic     rst_n;
	cpu_req_t cpu;
	mem_req_t mem;
	logic     dos;

	integer   seed;
	int       cyc;

	// model of the windows and dos as seen by the next sampled request
	win_cfg_t model_cfg [0:`ZX_WINDOWS-1];
	logic     model_dos;
	pend_t    pend_q [$];

	// expected outputs with the cycle they become visible
	mem_exp_t mem_q [$];
	dos_exp_t dos_q [$];
	mem_exp_t mem_item;
	dos_exp_t dos_item;
	logic     exp_dos;

	zx_mapper dut (
		.fclk  (fclk),
		.rst_n (rst_n),
		.cpu   (cpu),
		.mem   (mem),
		.dos   (dos)
	);

	bind zx_mapper zx_mapper_props props (
		.fclk  (fclk),
		.rst_n (rst_n),
		.cpu   (cpu),
		.mem   (mem),
		.dos   (dos)
	);

	always #5 fclk = ~fclk;

	////////////////////////////////////////////////////////////
	// checking
	////////////////////////////////////////////////////////////

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// rom drops the top page bit and ram keeps all six
	function automatic mem_req_t calc_expected(input win_cfg_t cfg, input cpu_addr_t za);
		mem_req_t r;
		r.valid = 1'b1;
		r.rom   = !cfg.ram;
		if (cfg.ram)
			r.addr = {cfg.page, za[`ZX_WIN_BITS-1:0]};
		else
			r.addr = {1'b0, cfg.page[4:0], za[`ZX_WIN_BITS-1:0]};
		return r;
	endfunction

	always @(posedge fclk)
	begin
		cyc = cyc + 1;
		if (cyc > TIMEOUT_CYCLES)
			fail_now($sformatf("simulation timed out after %0d cycles", cyc));
	end

	always @(negedge fclk)
	begin
		if (rst_n)
		begin
			while (dos_q.size() > 0 && dos_q[0].due <= cyc)
			begin
				dos_item = dos_q.pop_front();
				exp_dos  = dos_item.val;
			end
			check_value("dos", 32'(dos), 32'(exp_dos));
			if (mem_q.size() > 0 && mem_q[0].due == cyc)
			begin
				mem_item = mem_q.pop_front();
				if (!mem.valid)
					fail_now($sformatf("mem.valid missing for the read due in cycle %0d", cyc));
				check_value("mem.rom", 32'(mem.rom), 32'(mem_item.req.rom));
				check_value("mem.addr", 32'(mem.addr), 32'(mem_item.req.addr));
			end
			else if (mem.valid)
				fail_now($sformatf("mem.valid high in cycle %0d with no read due", cyc));
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	function automatic cpu_req_t idle_req();
		return '0;
	endfunction

	function automatic cpu_req_t io_req(input cpu_addr_t za, input cpu_data_t zd);
		cpu_req_t r;
		r       = '0;
		r.za    = za;
		r.zd    = zd;
		r.io_wr = 1'b1;
		return r;
	endfunction

	function automatic cpu_req_t read_req(input cpu_addr_t za, input logic m1);
		cpu_req_t r;
		r        = '0;
		r.za     = za;
		r.mem_rd = 1'b1;
		r.m1     = m1;
		return r;
	endfunction

	task automatic apply_pending(input int smp);
		pend_t p;
		while (pend_q.size() > 0 && pend_q[0].eff <= smp)
		begin
			p = pend_q.pop_front();
			model_cfg[p.win] = p.cfg;
		end
	endtask

	// entry needs rom in window 0 and exit is any fetch from 0x4000 up
	task automatic update_dos_model(input cpu_addr_t za);
		if (!model_dos)
		begin
			if (za[15:8] == `ZX_DOS_ENTRY && !model_cfg[0].ram)
				model_dos = 1'b1;
		end
		else if (za >= 16'h4000)
			model_dos = 1'b0;
	endtask

	// one bus cycle sampled at the next rising edge
	task automatic drive_cycle(input cpu_req_t req);
		int       smp;
		window_t  win;
		win_cfg_t cfg;
		@(posedge fclk);
		#1;
		cpu = req;
		smp = cyc + 1;
		apply_pending(smp);
		win = window_t'(req.za[15:`ZX_WIN_BITS]);
		if (req.io_wr && req.za[7:0] == `ZX_PAGER_PORT)
		begin
			cfg.ram  = req.zd[7];
			cfg.page = req.zd[`ZX_PAGE_BITS-1:0];
			// new mapping seen from the third cycle after the write
			pend_q.push_back(pend_t'{eff: smp + 3, win: win, cfg: cfg});
		end
		if (req.mem_rd)
		begin
			mem_q.push_back(mem_exp_t'{due: smp + 1,
				req: calc_expected(model_cfg[win], req.za)});
			if (req.m1)
			begin
				update_dos_model(req.za);
				dos_q.push_back(dos_exp_t'{due: smp, val: model_dos});
			end
		end
	endtask

	task automatic run_reset_reads();
		drive_cycle(read_req(16'h0123, 1'b0));
		drive_cycle(read_req(16'h4567, 1'b0));
		drive_cycle(read_req(16'h89AB, 1'b0));
		drive_cycle(read_req(16'hCDEF, 1'b0));
		repeat (2) drive_cycle(idle_req());
	endtask

	task automatic run_random_pages();
		logic [31:0] rnd;
		for (int r = 0; r < RAND_ROUNDS; r++)
		begin
			rnd = next_rand();
			drive_cycle(io_req({rnd[15:8], `ZX_PAGER_PORT}, rnd[23:16]));
			repeat (2) drive_cycle(idle_req());
			for (int k = 0; k < READS_PER_ROUND; k++)
			begin
				rnd = next_rand();
				if (rnd[31])
					drive_cycle(idle_req());
				drive_cycle(read_req(rnd[15:0], rnd[16]));
			end
		end
	endtask

	task automatic run_other_ports();
		logic [31:0] rnd;
		logic [7:0]  port;
		for (int r = 0; r < OTHER_ROUNDS; r++)
		begin
			rnd  = next_rand();
			port = rnd[7:0];
			if (port == `ZX_PAGER_PORT)
				port = port ^ 8'h01;
			drive_cycle(io_req({rnd[15:8], port}, rnd[23:16]));
			// pager byte on a memory read
			drive_cycle(read_req({rnd[31:24], `ZX_PAGER_PORT}, 1'b0));
			for (int w = 0; w < `ZX_WINDOWS; w++)
			begin
				rnd = next_rand();
				drive_cycle(read_req({2'(w), rnd[13:0]}, 1'b0));
			end
			drive_cycle(idle_req());
		end
	endtask

	// reads at N+1 .. N+4 straddle the mapping change
	task automatic run_write_ordering();
		logic [31:0] rnd;
		window_t     win;
		for (int r = 0; r < ORDER_ROUNDS; r++)
		begin
			rnd = next_rand();
			win = window_t'(rnd[15:14]);
			drive_cycle(io_req({win, rnd[13:8], `ZX_PAGER_PORT}, rnd[23:16]));
			for (int k = 0; k < 4; k++)
			begin
				rnd = next_rand();
				drive_cycle(read_req({win, rnd[13:0]}, 1'b0));
			end
			repeat (2) drive_cycle(idle_req());
		end
	endtask

	task automatic run_dos();
		drive_cycle(io_req(16'h00F7, 8'h03));
		repeat (3) drive_cycle(idle_req());
		drive_cycle(read_req(16'h3D10, 1'b0));
		drive_cycle(read_req(16'h3D20, 1'b1));
		drive_cycle(read_req(16'h1234, 1'b1));
		drive_cycle(read_req(16'h4000, 1'b1));
		// window 0 to ram so entry must not fire
		drive_cycle(io_req(16'h00F7, 8'h87));
		repeat (3) drive_cycle(idle_req());
		drive_cycle(read_req(16'h3D00, 1'b1));
		// back to rom page 0 with bit 6 set
		drive_cycle(io_req(16'h00F7, 8'h40));
		repeat (3) drive_cycle(idle_req());
		drive_cycle(read_req(16'h3DFF, 1'b1));
		drive_cycle(read_req(16'h8000, 1'b0));
		drive_cycle(read_req(16'hC000, 1'b1));
		repeat (2) drive_cycle(idle_req());
	endtask

	initial
	begin
		fclk      = 1'b0;
		rst_n     = 1'b0;
		cpu       = '0;
		seed      = 71270;
		cyc       = 0;
		model_dos = 1'b0;
		exp_dos   = 1'b0;
		model_cfg[0] = '{ram: 1'b0, page: `ZX_RST_PAGE0};
		model_cfg[1] = '{ram: 1'b1, page: `ZX_RST_PAGE1};
		model_cfg[2] = '{ram: 1'b1, page: `ZX_RST_PAGE2};
		model_cfg[3] = '{ram: 1'b1, page: `ZX_RST_PAGE3};
		repeat (5) @(posedge fclk);
		#1;
		rst_n = 1'b1;
		run_reset_reads();
		run_random_pages();
		run_other_ports();
		run_write_ordering();
		run_dos();
		while (mem_q.size() > 0 || dos_q.size() > 0)
			drive_cycle(idle_req());
		repeat (2) drive_cycle(idle_req());
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- zx_mapper.f
+incdir+verilog
verilog/zbus_pkg.sv
verilog/zmem_pkg.sv
verilog/port_decode.sv
verilog/page_file.sv
verilog/mem_translator.sv
verilog/zx_mapper.sv
bench/zx_mapper_props.sv
bench/zx_mapper_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the zx_mapper testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f zx_mapper.f --top-module zx_mapper_tb -Mdir "$BUILD_DIR"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/Vzx_mapper_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "pass message not found in $LOG"
	exit 1
fi
